// ==== source/mixer_pkg.sv ====
/* mixer package
   widths, value types, register map and pipeline latency shared by the complex mixer
*/
`default_nettype none

package mixer_pkg;

    // sample and coefficient widths
    localparam int SAMPLE_W   = 20;
    localparam int COEF_W     = 18;
    localparam int PROD_W     = SAMPLE_W + COEF_W + 1;  // full precision complex product
    localparam int NUM_COEF   = 4;
    localparam int COEF_SEL_W = 2;
    localparam int SHIFT_W    = 5;

    // register bus widths
    localparam int REG_ADDR_W = 4;
    localparam int REG_DATA_W = 32;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [COEF_W-1:0]   coef_t;
    typedef logic signed [PROD_W-1:0]   prod_t;
    typedef logic [COEF_SEL_W-1:0]      coef_sel_t;
    typedef logic [SHIFT_W-1:0]         shift_t;
    typedef logic [REG_ADDR_W-1:0]      reg_addr_t;
    typedef logic [REG_DATA_W-1:0]      reg_data_t;

    // a larger shift would leave nothing but sign bits in the output
    localparam shift_t MAX_SHIFT = shift_t'(19);

    // register map, coefficient k sits at 2k (real) and 2k+1 (imaginary)
    localparam reg_addr_t ADDR_COEF_BASE = reg_addr_t'(0);
    localparam reg_addr_t ADDR_SHIFT     = reg_addr_t'(8);

    // cycles from operands in to product out, and from in_valid to out_valid
    localparam int MULT_LATENCY  = 6;
    localparam int MIXER_LATENCY = MULT_LATENCY + 1;

endpackage

`default_nettype wire

// ==== source/mixer_cfg_if.sv ====
/* mixer configuration interface
   coefficient select going out to the register block, chosen coefficient and shift coming back
*/
`timescale 1ns/1ps
`default_nettype none

interface mixer_cfg_if;
    import mixer_pkg::*;

    coef_sel_t coef_sel;  // which of the four pairs the current sample wants
    coef_t     coef_re;
    coef_t     coef_im;
    shift_t    shift;     // output right shift, already clamped

    // register block side
    modport regs (
        input  coef_sel,
        output coef_re,
        output coef_im,
        output shift
    );

    // datapath side
    modport dp (
        output coef_sel,
        input  coef_re,
        input  coef_im,
        input  shift
    );

endinterface

`default_nettype wire

// ==== source/mixer_cfg_regs.sv ====
/* mixer configuration registers
   four complex coefficients and the output shift, with a write strobe and combinational readback
*/
`timescale 1ns/1ps
`default_nettype none

module mixer_cfg_regs (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 wr_en,
    input  wire mixer_pkg::reg_addr_t wr_addr,
    input  wire mixer_pkg::reg_data_t wr_data,
    input  wire mixer_pkg::reg_addr_t rd_addr,
    output mixer_pkg::reg_data_t      rd_data,
    mixer_cfg_if.regs                 cfg
);
    import mixer_pkg::*;

    coef_t     coef_re_q [NUM_COEF];
    coef_t     coef_im_q [NUM_COEF];
    shift_t    shift_q;

    reg_addr_t wr_off;
    reg_addr_t rd_off;
    coef_sel_t wr_idx;
    coef_sel_t rd_idx;
    logic      wr_is_coef;
    logic      rd_is_coef;
    coef_t     rd_coef;

    // a shift beyond the sample width is pinned to the largest useful value
    function automatic shift_t clamp_shift(input reg_data_t d);
        shift_t s;
        if (d > reg_data_t'(MAX_SHIFT)) begin
            s = MAX_SHIFT;
        end else begin
            s = d[SHIFT_W-1:0];
        end
        return s;
    endfunction

    // addresses below the base wrap around and fall out of the coefficient window
    assign wr_off     = wr_addr - ADDR_COEF_BASE;
    assign rd_off     = rd_addr - ADDR_COEF_BASE;
    assign wr_idx     = wr_off[COEF_SEL_W:1];  // bit 0 picks real or imaginary half
    assign rd_idx     = rd_off[COEF_SEL_W:1];
    assign wr_is_coef = (wr_off < reg_addr_t'(2 * NUM_COEF));
    assign rd_is_coef = (rd_off < reg_addr_t'(2 * NUM_COEF));

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < NUM_COEF; k++) begin
                coef_re_q[k] <= '0;
                coef_im_q[k] <= '0;
            end
            shift_q <= '0;
        end else if (wr_en) begin
            if (wr_is_coef) begin
                if (wr_off[0]) begin
                    coef_im_q[wr_idx] <= wr_data[COEF_W-1:0];
                end else begin
                    coef_re_q[wr_idx] <= wr_data[COEF_W-1:0];
                end
            end else if (wr_addr == ADDR_SHIFT) begin
                shift_q <= clamp_shift(wr_data);
            end
        end
    end

    assign rd_coef = rd_off[0] ? coef_im_q[rd_idx] : coef_re_q[rd_idx];

    always_comb begin
        rd_data = '0;  // unmapped addresses read as zero
        if (rd_is_coef) begin
            rd_data = {{(REG_DATA_W-COEF_W){rd_coef[COEF_W-1]}}, rd_coef};
        end else if (rd_addr == ADDR_SHIFT) begin
            rd_data = {{(REG_DATA_W-SHIFT_W){1'b0}}, shift_q};
        end
    end

    // pair lookup for the sample being presented, so a write shows up on the next sample
    assign cfg.coef_re = coef_re_q[cfg.coef_sel];
    assign cfg.coef_im = coef_im_q[cfg.coef_sel];
    assign cfg.shift   = shift_q;

endmodule

`default_nettype wire

// ==== source/complex_multiplier.sv ====
/* complex multiplier, (ar + j ai) * (br + j bi)
   six pipeline stages built on three real multipliers with a shared (ar - ai) * bi term
*/
`timescale 1ns/1ps
`default_nettype none

module complex_multiplier (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire mixer_pkg::sample_t ar,
    input  wire mixer_pkg::sample_t ai,
    input  wire mixer_pkg::coef_t   br,
    input  wire mixer_pkg::coef_t   bi,
    output mixer_pkg::prod_t        pr,
    output mixer_pkg::prod_t        pi
);
    import mixer_pkg::*;

    // operand delay lines, the suffix is the stage that holds the value
    sample_t ar_d1, ar_d2, ar_d3, ar_d4;
    sample_t ai_d1, ai_d2, ai_d3, ai_d4;
    coef_t   br_d1, br_d2, br_d3;
    coef_t   bi_d1, bi_d2, bi_d3;

    logic signed [SAMPLE_W:0] common_sum;  // ar - ai, one bit wider than a sample
    logic signed [COEF_W:0]   re_sum;      // br - bi
    logic signed [COEF_W:0]   im_sum;      // br + bi
    prod_t common_prod;
    prod_t common_d4;
    prod_t common_d5;
    prod_t re_prod;
    prod_t im_prod;
    prod_t pr_q;
    prod_t pi_q;

    // stages 1 to 4 only move the operands along so each multiplier sees one sample
    always_ff @(posedge clk) begin
        if (reset) begin
            ar_d1 <= '0;
            ar_d2 <= '0;
            ar_d3 <= '0;
            ar_d4 <= '0;
            ai_d1 <= '0;
            ai_d2 <= '0;
            ai_d3 <= '0;
            ai_d4 <= '0;
            br_d1 <= '0;
            br_d2 <= '0;
            br_d3 <= '0;
            bi_d1 <= '0;
            bi_d2 <= '0;
            bi_d3 <= '0;
        end else begin
            ar_d1 <= ar;  // the coefficient is captured on this same edge
            ar_d2 <= ar_d1;
            ar_d3 <= ar_d2;
            ar_d4 <= ar_d3;
            ai_d1 <= ai;
            ai_d2 <= ai_d1;
            ai_d3 <= ai_d2;
            ai_d4 <= ai_d3;
            br_d1 <= br;
            br_d2 <= br_d1;
            br_d3 <= br_d2;
            bi_d1 <= bi;
            bi_d2 <= bi_d1;
            bi_d3 <= bi_d2;
        end
    end

    // shared term, pre-add in stage 2 and multiply in stage 3
    always_ff @(posedge clk) begin
        if (reset) begin
            common_sum  <= '0;
            common_prod <= '0;
            common_d4   <= '0;
            common_d5   <= '0;
        end else begin
            common_sum  <= ar_d1 - ai_d1;
            common_prod <= common_sum * bi_d2;
            common_d4   <= common_prod;
            common_d5   <= common_d4;  // waits for the two path products
        end
    end

    // real part is (br - bi) * ar plus the shared term,
    // imaginary part is (br + bi) * ai plus the shared term
    always_ff @(posedge clk) begin
        if (reset) begin
            re_sum  <= '0;
            im_sum  <= '0;
            re_prod <= '0;
            im_prod <= '0;
            pr_q    <= '0;
            pi_q    <= '0;
        end else begin
            re_sum  <= br_d3 - bi_d3;
            im_sum  <= br_d3 + bi_d3;
            re_prod <= re_sum * ar_d4;
            im_prod <= im_sum * ai_d4;
            pr_q    <= re_prod + common_d5;
            pi_q    <= im_prod + common_d5;
        end
    end

    assign pr = pr_q;
    assign pi = pi_q;

endmodule

`default_nettype wire

// ==== source/output_scaler.sv ====
/* output scaler
   rounds the full product, shifts it right and saturates it to the sample width in one stage
*/
`timescale 1ns/1ps
`default_nettype none

module output_scaler (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               valid_in,
    input  wire mixer_pkg::prod_t   prod_re,
    input  wire mixer_pkg::prod_t   prod_im,
    input  wire mixer_pkg::shift_t  shift,
    output logic                    out_valid,
    output mixer_pkg::sample_t      pr,
    output mixer_pkg::sample_t      pi,
    output logic                    sat
);
    import mixer_pkg::*;

    sample_t pr_next;
    sample_t pi_next;
    logic    clip_re;
    logic    clip_im;

    // one guard bit above the product keeps the rounding add from wrapping
    function automatic sample_t scale_part(input prod_t p, input shift_t s, output logic clipped);
        logic [PROD_W:0]        half_step;
        logic signed [PROD_W:0] rounded;
        logic signed [PROD_W:0] shifted;
        sample_t                result;
        half_step = ({{PROD_W{1'b0}}, 1'b1} << s) >> 1;  // zero when s is zero
        rounded   = $signed({p[PROD_W-1], p}) + $signed(half_step);
        shifted   = rounded >>> s;
        // fits only if every bit from the sample's sign bit upward agrees
        clipped   = (shifted[PROD_W:SAMPLE_W-1] != {(PROD_W-SAMPLE_W+2){shifted[PROD_W]}});
        if (!clipped) begin
            result = shifted[SAMPLE_W-1:0];
        end else if (shifted[PROD_W]) begin
            result = {1'b1, {(SAMPLE_W-1){1'b0}}};
        end else begin
            result = {1'b0, {(SAMPLE_W-1){1'b1}}};
        end
        return result;
    endfunction

    always_comb begin
        pr_next = scale_part(prod_re, shift, clip_re);
        pi_next = scale_part(prod_im, shift, clip_im);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            pr        <= '0;
            pi        <= '0;
            sat       <= 1'b0;
        end else begin
            out_valid <= valid_in;
            pr        <= pr_next;
            pi        <= pi_next;
            sat       <= valid_in && (clip_re || clip_im);  // idle cycles never flag
        end
    end

endmodule

`default_nettype wire

// ==== source/mixer_datapath.sv ====
/* mixer datapath
   fetches the selected coefficient, multiplies, scales, and tracks sample validity
*/
`timescale 1ns/1ps
`default_nettype none

module mixer_datapath (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 in_valid,
    input  wire mixer_pkg::sample_t   ar,
    input  wire mixer_pkg::sample_t   ai,
    input  wire mixer_pkg::coef_sel_t coef_sel,
    mixer_cfg_if.dp                   cfg,
    output logic                      out_valid,
    output mixer_pkg::sample_t        pr,
    output mixer_pkg::sample_t        pi,
    output logic                      sat
);
    import mixer_pkg::*;

    logic [MULT_LATENCY-1:0] valid_sr;  // bit k is the valid of the sample in stage k+1
    prod_t                   prod_re;
    prod_t                   prod_im;

    // the register block answers combinationally within the same cycle
    assign cfg.coef_sel = coef_sel;

    complex_multiplier i_complex_multiplier (
        .clk   (clk),
        .reset (reset),
        .ar    (ar),
        .ai    (ai),
        .br    (cfg.coef_re),
        .bi    (cfg.coef_im),
        .pr    (prod_re),
        .pi    (prod_im)
    );

    // the multiplier runs every cycle, this line says which products count
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[MULT_LATENCY-2:0], in_valid};
        end
    end

    output_scaler i_output_scaler (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (valid_sr[MULT_LATENCY-1]),
        .prod_re   (prod_re),
        .prod_im   (prod_im),
        .shift     (cfg.shift),
        .out_valid (out_valid),
        .pr        (pr),
        .pi        (pi),
        .sat       (sat)
    );

endmodule

`default_nettype wire

// ==== source/complex_mixer.sv ====
/* complex mixer top level
   streaming complex gain with four programmable coefficients, rounding and saturation
*/
`timescale 1ns/1ps
`default_nettype none

module complex_mixer (
    input  wire logic                 clk,
    input  wire logic                 reset,
    // register write and readback
    input  wire logic                 wr_en,
    input  wire mixer_pkg::reg_addr_t wr_addr,
    input  wire mixer_pkg::reg_data_t wr_data,
    input  wire mixer_pkg::reg_addr_t rd_addr,
    output mixer_pkg::reg_data_t      rd_data,
    // sample stream in, one sample per cycle at most
    input  wire logic                 in_valid,
    input  wire mixer_pkg::sample_t   ar,
    input  wire mixer_pkg::sample_t   ai,
    input  wire mixer_pkg::coef_sel_t coef_sel,
    // scaled stream out, seven cycles behind
    output logic                      out_valid,
    output mixer_pkg::sample_t        pr,
    output mixer_pkg::sample_t        pi,
    output logic                      sat
);

    mixer_cfg_if cfg_if ();

    mixer_cfg_regs i_mixer_cfg_regs (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .cfg     (cfg_if.regs)
    );

    mixer_datapath i_mixer_datapath (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .ar        (ar),
        .ai        (ai),
        .coef_sel  (coef_sel),
        .cfg       (cfg_if.dp),
        .out_valid (out_valid),
        .pr        (pr),
        .pi        (pi),
        .sat       (sat)
    );

endmodule

`default_nettype wire

// ==== verif/complex_mixer_cases.svh ====
/* complex mixer test cases
   directed rows with hand-worked results, and the reference model for the random stream
*/
`ifndef COMPLEX_MIXER_CASES_SVH
`define COMPLEX_MIXER_CASES_SVH

// columns are select, ar, ai, shift, expected pr, expected pi, expected sat
typedef struct packed {
    coef_sel_t sel;
    sample_t   ar;
    sample_t   ai;
    shift_t    shift;
    sample_t   pr;
    sample_t   pi;
    logic      sat;
} case_row_t;

localparam int NUM_ROWS = 13;

// coefficients are (3,-2) (-131072,131071) (1,0) (-5,7), rows of equal shift stay together
localparam case_row_t CASE_ROWS [NUM_ROWS] = '{
    '{2'd0, 20'sd100, 20'sd50, 5'd0, 20'sd400, -20'sd50, 1'b0},
    '{2'd1, 20'sd1, 20'sd1, 5'd0, -20'sd262143, -20'sd1, 1'b0},
    '{2'd2, 20'sd12345, -20'sd6789, 5'd0, 20'sd12345, -20'sd6789, 1'b0},
    '{2'd3, -20'sd20, 20'sd9, 5'd0, 20'sd37, -20'sd185, 1'b0},
    '{2'd2, 20'sh80000, 20'sd524287, 5'd0, 20'sh80000, 20'sd524287, 1'b0},  // identity at full scale
    '{2'd1, 20'sh80000, 20'sd0, 5'd0, 20'sd524287, 20'sh80000, 1'b1},
    '{2'd0, -20'sd7, 20'sd4, 5'd0, -20'sd13, 20'sd26, 1'b0},
    '{2'd1, 20'sd524287, 20'sd524287, 5'd0, 20'sh80000, -20'sd524287, 1'b1},
    // shift 17 rounds half up, so -1.5 goes to -1 and -0.5 goes to 0
    '{2'd1, 20'sd3, 20'sd0, 5'd17, -20'sd3, 20'sd3, 1'b0},
    '{2'd2, -20'sd196608, 20'sd196608, 5'd17, -20'sd1, 20'sd2, 1'b0},
    '{2'd1, 20'sd100, -20'sd100, 5'd17, 20'sd0, 20'sd200, 1'b0},
    '{2'd2, -20'sd65536, -20'sd65535, 5'd17, 20'sd0, 20'sd0, 1'b0},
    '{2'd3, 20'sd131072, 20'sd0, 5'd17, -20'sd5, 20'sd7, 1'b0}
};

// one part of the output from its exact value, round half up then clamp
function automatic sample_t model_part(input longint exact, input shift_t s, output logic clipped);
    longint v;
    longint hi;
    hi = (longint'(1) <<< (SAMPLE_W - 1)) - 1;
    v  = exact;
    if (s != 0) begin
        v = v + (longint'(1) <<< (s - 1));
    end
    v       = v >>> s;
    clipped = (v > hi) || (v < -hi - 1);
    if (v > hi) begin
        v = hi;
    end else if (v < -hi - 1) begin
        v = -hi - 1;
    end
    return sample_t'(v);
endfunction

`endif

// ==== verif/complex_mixer_tb.sv ====
/* complex mixer testbench
   register checks, a table driven stream, a seeded random stream and write timing against a model
*/
`timescale 1ns/1ps
`default_nettype none

module complex_mixer_tb;
    import mixer_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int NUM_RANDOM   = 200;
    localparam int RANDOM_SHIFT = 10;

    `include "complex_mixer_cases.svh"

    localparam int WATCHDOG_NS = (NUM_ROWS + NUM_RANDOM + 50) * CLK_PERIOD * 4;

    typedef struct {
        sample_t pr;
        sample_t pi;
        logic    sat;
        int      issue;  // cycle in which the sample was driven
    } expect_t;

    logic      clk;
    logic      reset;
    logic      wr_en;
    reg_addr_t wr_addr;
    reg_data_t wr_data;
    reg_addr_t rd_addr;
    reg_data_t rd_data;
    logic      in_valid;
    sample_t   ar;
    sample_t   ai;
    coef_sel_t coef_sel;
    logic      out_valid;
    sample_t   pr;
    sample_t   pi;
    logic      sat;

    expect_t exp_q [$];
    int      errors = 0;
    int      cycle = 0;
    integer  seed = 32'hcc32b043;
    coef_t   tb_re [NUM_COEF];
    coef_t   tb_im [NUM_COEF];
    shift_t  cur_shift;

    complex_mixer i_complex_mixer (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .in_valid  (in_valid),
        .ar        (ar),
        .ai        (ai),
        .coef_sel  (coef_sel),
        .out_valid (out_valid),
        .pr        (pr),
        .pi        (pi),
        .sat       (sat)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %0h expected %0h at cycle %0d", name, got, exp, cycle);
            errors++;
        end
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        @(posedge clk);
        wr_en    <= 1'b1;
        wr_addr  <= addr;
        wr_data  <= data;
        in_valid <= 1'b0;
    endtask

    task automatic idle();
        @(posedge clk);
        wr_en    <= 1'b0;
        in_valid <= 1'b0;
    endtask

    task automatic read_check(input reg_addr_t addr, input reg_data_t exp);
        idle();
        rd_addr <= addr;
        @(negedge clk);  // readback is combinational, settled by mid cycle
        check_value("rd_data", rd_data, exp);
    endtask

    task automatic send_sample(input coef_sel_t sel, input sample_t a_r, input sample_t a_i,
                               input sample_t e_pr, input sample_t e_pi, input logic e_sat);
        expect_t e;
        e.pr    = e_pr;
        e.pi    = e_pi;
        e.sat   = e_sat;
        @(posedge clk);
        e.issue  = cycle;
        wr_en    <= 1'b0;
        in_valid <= 1'b1;
        coef_sel <= sel;
        ar       <= a_r;
        ai       <= a_i;
        exp_q.push_back(e);
    endtask

    // expected result from the coefficients the tb wrote and the current shift
    task automatic send_model(input coef_sel_t sel, input sample_t a_r, input sample_t a_i);
        longint  re;
        longint  im;
        logic    clip_re;
        logic    clip_im;
        sample_t e_pr;
        sample_t e_pi;
        re   = longint'(a_r) * longint'(tb_re[sel]) - longint'(a_i) * longint'(tb_im[sel]);
        im   = longint'(a_r) * longint'(tb_im[sel]) + longint'(a_i) * longint'(tb_re[sel]);
        e_pr = model_part(re, cur_shift, clip_re);
        e_pi = model_part(im, cur_shift, clip_im);
        send_sample(sel, a_r, a_i, e_pr, e_pi, clip_re || clip_im);
    endtask

    task automatic drain();
        int n;
        n = 0;
        idle();
        while (exp_q.size() != 0 && n < 4 * MIXER_LATENCY) begin
            @(negedge clk);
            n++;
        end
    endtask

    task automatic set_shift(input shift_t s);
        write_reg(ADDR_SHIFT, reg_data_t'(s));
        idle();
        cur_shift = s;
    endtask

    // every output is matched in order and must come exactly seven cycles after its input
    always @(negedge clk) begin
        expect_t e;
        if (!reset && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("unexpected output at cycle %0d with no sample waiting for it", cycle);
                errors++;
            end else begin
                e = exp_q.pop_front();
                check_value("pr", pr, e.pr);
                check_value("pi", pi, e.pi);
                check_value("sat", sat, e.sat);
                check_value("latency", cycle - e.issue, MIXER_LATENCY);
            end
        end else if (!reset) begin
            check_value("sat", sat, 1'b0);  // flag only rides on valid outputs
        end
        cycle = cycle + 1;
    end

    initial begin
        sample_t   rr;
        sample_t   ri;
        coef_sel_t rs;
        reset    = 1'b1;
        wr_en    = 1'b0;
        wr_addr  = '0;
        wr_data  = '0;
        rd_addr  = '0;
        in_valid = 1'b0;
        ar       = '0;
        ai       = '0;
        coef_sel = '0;
        tb_re    = '{coef_t'(3), coef_t'(-131072), coef_t'(1), coef_t'(-5)};
        tb_im    = '{coef_t'(-2), coef_t'(131071), coef_t'(0), coef_t'(7)};
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("out_valid", out_valid, 1'b0);
        check_value("sat", sat, 1'b0);
        for (int a = 0; a < 16; a++) begin
            read_check(reg_addr_t'(a), '0);
        end
        for (int k = 0; k < NUM_COEF; k++) begin
            write_reg(reg_addr_t'(ADDR_COEF_BASE + 2 * k), reg_data_t'(int'(tb_re[k])));
            write_reg(reg_addr_t'(ADDR_COEF_BASE + 2 * k + 1), reg_data_t'(int'(tb_im[k])));
        end
        for (int k = 0; k < NUM_COEF; k++) begin
            read_check(reg_addr_t'(ADDR_COEF_BASE + 2 * k), reg_data_t'(int'(tb_re[k])));
            read_check(reg_addr_t'(ADDR_COEF_BASE + 2 * k + 1), reg_data_t'(int'(tb_im[k])));
        end
        write_reg(ADDR_SHIFT, reg_data_t'(25));
        read_check(ADDR_SHIFT, reg_data_t'(19));
        read_check(reg_addr_t'(9), '0);
        cur_shift = shift_t'(19);

        // rows go back to back, the shift only moves once the pipeline is empty
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (CASE_ROWS[r].shift != cur_shift) begin
                drain();
                set_shift(CASE_ROWS[r].shift);
            end
            send_sample(CASE_ROWS[r].sel, CASE_ROWS[r].ar, CASE_ROWS[r].ai,
                        CASE_ROWS[r].pr, CASE_ROWS[r].pi, CASE_ROWS[r].sat);
        end
        drain();
        set_shift(shift_t'(RANDOM_SHIFT));
        for (int n = 0; n < NUM_RANDOM; n++) begin
            if (($random(seed) & 3) == 0) begin
                idle();
            end
            rs = coef_sel_t'($random(seed));
            rr = sample_t'($random(seed));
            ri = sample_t'($random(seed));
            send_model(rs, rr, ri);
        end
        drain();

        // rewrite coefficient 3 between two samples, the second one must see the new value
        send_model(coef_sel_t'(3), sample_t'(1000), sample_t'(-300));
        tb_re[3] = coef_t'(200);
        write_reg(reg_addr_t'(ADDR_COEF_BASE + 6), reg_data_t'(200));
        send_model(coef_sel_t'(3), sample_t'(1000), sample_t'(-300));
        drain();

        if (exp_q.size() != 0) begin
            $display("missing outputs, %0d samples never came out", exp_q.size());
            errors++;
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, the run did not finish, errors so far %0d",
                 WATCHDOG_NS, errors);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== complex_mixer.f ====
+incdir+verif
source/mixer_pkg.sv
source/mixer_cfg_if.sv
source/mixer_cfg_regs.sv
source/complex_multiplier.sv
source/output_scaler.sv
source/mixer_datapath.sv
source/complex_mixer.sv
verif/complex_mixer_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal -j 0
TOP       := complex_mixer_tb
FILELIST  := complex_mixer.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SOURCES := $(wildcard source/*.sv verif/*.sv verif/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
